// ==== design/cnn_pool_pkg.sv ====
package cnn_pool_pkg;

	// map limits
	localparam int FM_SIZE_MAX = 8;
	localparam int DEPTH_MAX   = 4;
	localparam int BANK_WORDS  = DEPTH_MAX * FM_SIZE_MAX * FM_SIZE_MAX; // words per bank

	typedef logic [15:0] fp16_t;   // sign, 5 bit exponent, 10 bit mantissa
	typedef logic [7:0]  fm_addr_t; // word inside one bank
	typedef logic [8:0]  ram_addr_t; // bank bit on top
	typedef logic [3:0]  dim_t;
	typedef logic [2:0]  win_t;    // 1 to 4
	typedef logic [2:0]  slice_t;

	typedef logic [11:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;

	// byte offsets on the bus
	localparam wb_addr_t REG_CTRL       = 12'h000;
	localparam wb_addr_t REG_STATUS     = 12'h004;
	localparam wb_addr_t REG_CFG        = 12'h008;
	localparam wb_addr_t FM_WINDOW_BASE = 12'h400; // one word per 4 bytes

	typedef struct packed {
		dim_t   fm_size;
		win_t   win;
		slice_t depth;
	} pool_cfg_t;

	// engine write into the output bank
	typedef struct packed {
		logic      we;
		ram_addr_t addr;
		fp16_t     data;
	} fm_wr_t;

	// window markers riding along with a read
	typedef struct packed {
		logic first;
		logic last;
	} rd_tag_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DRAIN,
		DONE
	} ctrl_state_t;

endpackage

// ==== design/fm_ram.sv ====
`timescale 1ns/1ps

module fm_ram (
	input  logic                    clk,
	// host side, read and write share the address
	input  cnn_pool_pkg::ram_addr_t host_addr_i,
	input  logic                    host_we_i,
	input  cnn_pool_pkg::fp16_t     host_data_i,
	output cnn_pool_pkg::fp16_t     host_data_o,
	// engine side
	input  cnn_pool_pkg::ram_addr_t rd_addr_i,
	output cnn_pool_pkg::fp16_t     rd_data_o,
	input  cnn_pool_pkg::fm_wr_t    wr_i
);

	localparam int RAM_WORDS = 2 * cnn_pool_pkg::BANK_WORDS; // ping and pong

	cnn_pool_pkg::fp16_t mem [RAM_WORDS];

	always_ff @(posedge clk) begin
		if (wr_i.we) begin
			mem[wr_i.addr] <= wr_i.data; // pooled result
		end
		if (host_we_i) begin
			mem[host_addr_i] <= host_data_i;
		end
	end

	// both read ports have one cycle of latency
	always_ff @(posedge clk) begin
		host_data_o <= mem[host_addr_i];
		rd_data_o   <= mem[rd_addr_i];
	end

endmodule

// ==== design/wb_pool_regs.sv ====
`timescale 1ns/1ps

module wb_pool_regs (
	input  logic                    clk,
	input  logic                    rst,
	// wishbone classic slave
	input  logic                    cyc_i,
	input  logic                    stb_i,
	input  logic                    we_i,
	input  cnn_pool_pkg::wb_addr_t  adr_i,
	input  cnn_pool_pkg::wb_data_t  dat_i,
	output cnn_pool_pkg::wb_data_t  dat_o,
	output logic                    ack_o,
	// engine status and control
	input  logic                    busy_i,
	input  logic                    done_i,
	input  logic                    in_bank_i,
	output cnn_pool_pkg::pool_cfg_t cfg_o,
	output logic                    start_o,
	// host port of the feature map RAM
	output cnn_pool_pkg::ram_addr_t host_addr_o,
	output logic                    host_we_o,
	output cnn_pool_pkg::fp16_t     host_data_o,
	input  cnn_pool_pkg::fp16_t     host_data_i
);

	localparam int CFG_BITS = $bits(cnn_pool_pkg::pool_cfg_t);

	logic                   req;
	logic                   is_fm;
	logic                   wr_ok; // write while the engine is idle
	cnn_pool_pkg::wb_data_t reg_rd_q;
	logic                   sel_fm_q;

	// new request only, the ack cycle is never taken as a second one
	assign req   = cyc_i & stb_i & ~ack_o;
	assign is_fm = (adr_i[11:10] == cnn_pool_pkg::FM_WINDOW_BASE[11:10]);
	assign wr_ok = req & we_i & ~busy_i;

	// RAM address goes out on the request edge, data returns with ack
	assign host_addr_o = {in_bank_i, adr_i[9:2]};
	assign host_we_o   = wr_ok & is_fm;
	assign host_data_o = dat_i[15:0];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ack_o   <= 1'b0;
			start_o <= 1'b0;
			cfg_o   <= '{fm_size: cnn_pool_pkg::dim_t'(cnn_pool_pkg::FM_SIZE_MAX),
				win: 3'd2, depth: 3'd1};
		end else begin
			ack_o   <= req;
			start_o <= wr_ok & (adr_i == cnn_pool_pkg::REG_CTRL) & dat_i[0];
			if (wr_ok && adr_i == cnn_pool_pkg::REG_CFG) begin
				cfg_o <= cnn_pool_pkg::pool_cfg_t'(dat_i[CFG_BITS-1:0]);
			end
		end
	end

	// register read data is captured at the request edge
	always_ff @(posedge clk) begin
		if (req) begin
			sel_fm_q <= is_fm;
			case (adr_i)
				cnn_pool_pkg::REG_STATUS: reg_rd_q <= {30'b0, done_i, busy_i};
				cnn_pool_pkg::REG_CFG:    reg_rd_q <= cnn_pool_pkg::wb_data_t'(cfg_o);
				default:                  reg_rd_q <= '0; // ctrl reads as zero
			endcase
		end
	end

	assign dat_o = sel_fm_q ? {16'b0, host_data_i} : reg_rd_q;

endmodule

// ==== design/pool_addr_gen.sv ====
`timescale 1ns/1ps

module pool_addr_gen (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    run_i,
	input  logic                    in_bank_i,
	input  cnn_pool_pkg::pool_cfg_t cfg_i,
	output cnn_pool_pkg::ram_addr_t rd_addr_o,
	output cnn_pool_pkg::rd_tag_t   tag_o,
	output cnn_pool_pkg::ram_addr_t wr_addr_o,
	output logic                    last_issue_o
);

	cnn_pool_pkg::win_t     wx; // column inside the window
	cnn_pool_pkg::win_t     wy; // row inside the window
	cnn_pool_pkg::dim_t     ox;
	cnn_pool_pkg::dim_t     oy;
	cnn_pool_pkg::slice_t   sl;
	cnn_pool_pkg::dim_t     out_size;
	cnn_pool_pkg::dim_t     row;
	cnn_pool_pkg::dim_t     col;
	cnn_pool_pkg::fm_addr_t rd_off;
	cnn_pool_pkg::fm_addr_t wr_off;
	logic                   wx_end;
	logic                   wy_end;
	logic                   ox_end;
	logic                   oy_end;
	logic                   sl_end;

	// leftover rows and columns are never visited
	assign out_size = cfg_i.fm_size / cnn_pool_pkg::dim_t'(cfg_i.win);

	assign wx_end = (wx == cfg_i.win - 3'd1);
	assign wy_end = (wy == cfg_i.win - 3'd1);
	assign ox_end = (ox == out_size - 4'd1);
	assign oy_end = (oy == out_size - 4'd1);
	assign sl_end = (sl == cfg_i.depth - 3'd1);

	assign row = oy * cnn_pool_pkg::dim_t'(cfg_i.win) + cnn_pool_pkg::dim_t'(wy);
	assign col = ox * cnn_pool_pkg::dim_t'(cfg_i.win) + cnn_pool_pkg::dim_t'(wx);

	assign rd_off = cnn_pool_pkg::fm_addr_t'(sl) * cfg_i.fm_size * cfg_i.fm_size
		+ cnn_pool_pkg::fm_addr_t'(row) * cfg_i.fm_size + cnn_pool_pkg::fm_addr_t'(col);
	assign wr_off = cnn_pool_pkg::fm_addr_t'(sl) * out_size * out_size
		+ cnn_pool_pkg::fm_addr_t'(oy) * out_size + cnn_pool_pkg::fm_addr_t'(ox);

	assign rd_addr_o = {in_bank_i, rd_off};
	assign wr_addr_o = {~in_bank_i, wr_off}; // result lands in the other bank

	assign tag_o.first  = run_i & (wx == '0) & (wy == '0);
	assign tag_o.last   = run_i & wx_end & wy_end;
	assign last_issue_o = tag_o.last & ox_end & oy_end & sl_end;

	// window offset is innermost, slice outermost
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wx <= '0;
			wy <= '0;
			ox <= '0;
			oy <= '0;
			sl <= '0;
		end else if (!run_i) begin
			wx <= '0; // every layer starts at the origin
			wy <= '0;
			ox <= '0;
			oy <= '0;
			sl <= '0;
		end else begin
			wx <= wx_end ? '0 : wx + 3'd1;
			if (wx_end) begin
				wy <= wy_end ? '0 : wy + 3'd1;
				if (wy_end) begin
					ox <= ox_end ? '0 : ox + 4'd1;
					if (ox_end) begin
						oy <= oy_end ? '0 : oy + 4'd1;
						if (oy_end) begin
							sl <= sl_end ? '0 : sl + 3'd1;
						end
					end
				end
			end
		end
	end

endmodule

// ==== design/max_pool_unit.sv ====
`timescale 1ns/1ps

module max_pool_unit (
	input  logic                    clk,
	input  logic                    rst,
	input  cnn_pool_pkg::fp16_t     data_i,    // RAM output, one cycle behind the tag
	input  cnn_pool_pkg::rd_tag_t   tag_i,
	input  cnn_pool_pkg::ram_addr_t wr_addr_i,
	output cnn_pool_pkg::fm_wr_t    wr_o
);

	cnn_pool_pkg::rd_tag_t   tag_q;
	cnn_pool_pkg::ram_addr_t addr_q;
	cnn_pool_pkg::fp16_t     max_q;
	cnn_pool_pkg::fp16_t     cur_max;
	logic                    we_q;
	cnn_pool_pkg::ram_addr_t wr_addr_q;
	cnn_pool_pkg::fp16_t     wr_data_q;

	// strict float16 greater than, sign first then magnitude
	function automatic logic fp16_gt(cnn_pool_pkg::fp16_t a, cnn_pool_pkg::fp16_t b);
		if (a[15] != b[15]) begin
			return b[15]; // positive side wins
		end
		if (!a[15]) begin
			return a[14:0] > b[14:0];
		end
		return a[14:0] < b[14:0];
	endfunction

	// ties keep the earlier element
	assign cur_max = (tag_q.first || fp16_gt(data_i, max_q)) ? data_i : max_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tag_q <= '0;
			we_q  <= 1'b0;
		end else begin
			tag_q <= tag_i;
			we_q  <= tag_q.last;
		end
	end

	always_ff @(posedge clk) begin
		addr_q    <= wr_addr_i;
		max_q     <= cur_max;
		wr_addr_q <= addr_q;
		wr_data_q <= cur_max;
	end

	assign wr_o = '{we: we_q, addr: wr_addr_q, data: wr_data_q};

endmodule

// ==== design/pool_layer_ctrl.sv ====
`timescale 1ns/1ps

module pool_layer_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic start_i,
	input  logic last_issue_i,
	output logic run_o,
	output logic busy_o,
	output logic done_o,
	output logic in_bank_o
);

	cnn_pool_pkg::ctrl_state_t state;
	logic                      drain_cnt; // two drain cycles

	assign run_o  = (state == cnn_pool_pkg::RUN);
	assign busy_o = (state == cnn_pool_pkg::RUN) || (state == cnn_pool_pkg::DRAIN);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= cnn_pool_pkg::IDLE;
			drain_cnt <= 1'b0;
			done_o    <= 1'b0;
			in_bank_o <= 1'b0;
		end else begin
			case (state)
				cnn_pool_pkg::IDLE: begin
					if (start_i) begin
						state  <= cnn_pool_pkg::RUN;
						done_o <= 1'b0;
					end
				end
				cnn_pool_pkg::RUN: begin
					if (last_issue_i) begin
						state     <= cnn_pool_pkg::DRAIN;
						drain_cnt <= 1'b0;
					end
				end
				cnn_pool_pkg::DRAIN: begin
					// last read data, then the last write
					if (drain_cnt) begin
						state     <= cnn_pool_pkg::DONE;
						done_o    <= 1'b1;
						in_bank_o <= ~in_bank_o; // result becomes next input
					end else begin
						drain_cnt <= 1'b1;
					end
				end
				default: begin
					state <= cnn_pool_pkg::IDLE; // done stays up until next start
				end
			endcase
		end
	end

endmodule

// ==== design/cnn_pool_top.sv ====
`timescale 1ns/1ps

module cnn_pool_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cyc_i,
	input  logic                   stb_i,
	input  logic                   we_i,
	input  cnn_pool_pkg::wb_addr_t adr_i,
	input  cnn_pool_pkg::wb_data_t dat_i,
	output cnn_pool_pkg::wb_data_t dat_o,
	output logic                   ack_o
);

	cnn_pool_pkg::pool_cfg_t cfg;
	logic                    start;
	logic                    busy;
	logic                    done;
	logic                    in_bank;
	logic                    run;
	logic                    last_issue;
	cnn_pool_pkg::ram_addr_t host_addr;
	logic                    host_we;
	cnn_pool_pkg::fp16_t     host_wdata;
	cnn_pool_pkg::fp16_t     host_rdata;
	cnn_pool_pkg::ram_addr_t rd_addr;
	cnn_pool_pkg::fp16_t     rd_data;
	cnn_pool_pkg::rd_tag_t   tag;
	cnn_pool_pkg::ram_addr_t wr_addr;
	cnn_pool_pkg::fm_wr_t    fm_wr;

	wb_pool_regs wb_pool_regs_inst (
		.clk, .rst, .cyc_i, .stb_i, .we_i, .adr_i, .dat_i, .dat_o, .ack_o,
		.busy_i(busy), .done_i(done), .in_bank_i(in_bank),
		.cfg_o(cfg), .start_o(start),
		.host_addr_o(host_addr), .host_we_o(host_we),
		.host_data_o(host_wdata), .host_data_i(host_rdata)
	);

	pool_layer_ctrl pool_layer_ctrl_inst (
		.clk, .rst, .start_i(start), .last_issue_i(last_issue),
		.run_o(run), .busy_o(busy), .done_o(done), .in_bank_o(in_bank)
	);

	pool_addr_gen pool_addr_gen_inst (
		.clk, .rst, .run_i(run), .in_bank_i(in_bank), .cfg_i(cfg),
		.rd_addr_o(rd_addr), .tag_o(tag), .wr_addr_o(wr_addr),
		.last_issue_o(last_issue)
	);

	fm_ram fm_ram_inst (
		.clk, .host_addr_i(host_addr), .host_we_i(host_we),
		.host_data_i(host_wdata), .host_data_o(host_rdata),
		.rd_addr_i(rd_addr), .rd_data_o(rd_data), .wr_i(fm_wr)
	);

	max_pool_unit max_pool_unit_inst (
		.clk, .rst, .data_i(rd_data), .tag_i(tag), .wr_addr_i(wr_addr), .wr_o(fm_wr)
	);

endmodule

// ==== verif/tb_pool_checks.svh ====
// ordering key for float16, a larger key is a larger value
function automatic logic [15:0] fp16_key(input cnn_pool_pkg::fp16_t v);
	if (v[15]) begin
		return {1'b0, ~v[14:0]}; // negatives sit below every positive
	end
	return {1'b1, v[14:0]};
endfunction

// reference max pooling, fm_in to exp_out, same layout as the RAM banks
task automatic pool_model(input int fm, input int win, input int depth);
	int out;
	int base;
	int idx;
	cnn_pool_pkg::fp16_t best;
	cnn_pool_pkg::fp16_t v;
	out = fm / win; // leftover rows and columns drop out here
	for (int s = 0; s < depth; s++) begin
		for (int oy = 0; oy < out; oy++) begin
			for (int ox = 0; ox < out; ox++) begin
				base = s * fm * fm + oy * win * fm + ox * win;
				best = fm_in[base[7:0]];
				for (int wy = 0; wy < win; wy++) begin
					for (int wx = 0; wx < win; wx++) begin
						idx = base + wy * fm + wx;
						v = fm_in[idx[7:0]];
						if (fp16_key(v) > fp16_key(best)) begin
							best = v; // strict, a tie keeps the earlier one
						end
					end
				end
				idx = s * out * out + oy * out + ox;
				exp_out[idx[7:0]] = best;
			end
		end
	end
endtask

task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	checks++;
	assert (actual === expected) else begin
		$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
		errors++;
	end
endtask

// ==== verif/tb_cnn_pool.sv ====
`timescale 1ns/1ps

module tb_cnn_pool;

	localparam int WB_TIMEOUT = 20;  // cycles to wait for ack
	localparam int DONE_POLLS = 400; // status reads before giving up

	logic                   clk;
	logic                   rst;
	logic                   cyc;
	logic                   stb;
	logic                   we;
	cnn_pool_pkg::wb_addr_t adr;
	cnn_pool_pkg::wb_data_t dat_w;
	cnn_pool_pkg::wb_data_t dat_r;
	logic                   ack;

	logic [31:0]         lcg_state = 32'd34;
	int                  errors = 0;
	int                  checks = 0;
	int                  ack_latency;
	int                  layer_cycles = 0;
	logic                counting = 1'b0;
	cnn_pool_pkg::fp16_t fm_in [cnn_pool_pkg::BANK_WORDS];
	cnn_pool_pkg::fp16_t exp_out [cnn_pool_pkg::BANK_WORDS];

	cnn_pool_top cnn_pool_top_inst (
		.clk, .rst, .cyc_i(cyc), .stb_i(stb), .we_i(we), .adr_i(adr),
		.dat_i(dat_w), .dat_o(dat_r), .ack_o(ack)
	);

	`include "tb_pool_checks.svh"

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// rising edges from the start pulse up to done
	always @(negedge clk) begin
		if (cnn_pool_top_inst.start) begin
			layer_cycles = 0;
			counting = 1'b1;
		end
		if (counting) begin
			if (cnn_pool_top_inst.done && !cnn_pool_top_inst.start) begin
				counting = 1'b0;
			end else begin
				layer_cycles++;
			end
		end
	end

	// random float16 with the exponent kept below 31 so never inf or nan
	function automatic cnn_pool_pkg::fp16_t next_rand_fp16();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {lcg_state[31], lcg_state[30:26] % 5'd31, lcg_state[25:16]};
	endfunction

	function automatic cnn_pool_pkg::wb_addr_t window_addr(input int i);
		return cnn_pool_pkg::wb_addr_t'(int'(cnn_pool_pkg::FM_WINDOW_BASE) + 4 * i);
	endfunction

	function automatic cnn_pool_pkg::wb_data_t cfg_word(input int fm, input int win,
			input int depth);
		return cnn_pool_pkg::wb_data_t'((fm << 6) | (win << 3) | depth);
	endfunction

	// one classic cycle where every ack must come one clock after the request
	task automatic run_bus_cycle(input logic wr, input cnn_pool_pkg::wb_addr_t a,
			input cnn_pool_pkg::wb_data_t d, output cnn_pool_pkg::wb_data_t q);
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = wr;
		adr = a;
		dat_w = d;
		ack_latency = 0;
		do begin
			@(negedge clk);
			ack_latency++;
		end while (!ack && ack_latency < WB_TIMEOUT);
		if (!ack) begin
			$display("no ack from the DUT for the access at address %h", a);
			errors++;
		end else begin
			check_value("ack latency", 1, ack_latency);
		end
		q = dat_r;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic write_word(input cnn_pool_pkg::wb_addr_t a, input cnn_pool_pkg::wb_data_t d);
		cnn_pool_pkg::wb_data_t unused;
		run_bus_cycle(1'b1, a, d, unused);
	endtask

	task automatic read_word(input cnn_pool_pkg::wb_addr_t a, output cnn_pool_pkg::wb_data_t q);
		run_bus_cycle(1'b0, a, '0, q);
	endtask

	// leftover rows and columns get the largest finite value
	task automatic load_map(input int fm, input int win, input int depth);
		int covered;
		int row;
		int col;
		cnn_pool_pkg::fp16_t v;
		covered = (fm / win) * win;
		for (int i = 0; i < depth * fm * fm; i++) begin
			row = (i % (fm * fm)) / fm;
			col = i % fm;
			v = next_rand_fp16();
			if (row >= covered || col >= covered) begin
				v = 16'h7bff;
			end
			fm_in[i[7:0]] = v;
			write_word(window_addr(i), {16'b0, v});
		end
	endtask

	task automatic wait_done(input string name);
		cnn_pool_pkg::wb_data_t st;
		int polls;
		polls = 0;
		do begin
			read_word(cnn_pool_pkg::REG_STATUS, st);
			polls++;
		end while (!st[1] && polls < DONE_POLLS);
		if (!st[1]) begin
			$display("layer %s never reported done", name);
			errors++;
		end else begin
			check_value({name, " status at done"}, 32'd2, st);
		end
	endtask

	task automatic run_layer(input string name, input int fm, input int win, input int depth,
			input bit disturb);
		int out;
		cnn_pool_pkg::wb_data_t q;
		out = fm / win;
		pool_model(fm, win, depth);
		write_word(cnn_pool_pkg::REG_CFG, cfg_word(fm, win, depth));
		write_word(cnn_pool_pkg::REG_CTRL, 32'd1);
		if (disturb) begin
			read_word(cnn_pool_pkg::REG_STATUS, q);
			check_value({name, " status while busy"}, 32'd1, q);
			// last word of the map is read only near the end of the layer
			write_word(window_addr(depth * fm * fm - 1), 32'h7bff);
			write_word(cnn_pool_pkg::REG_CFG, cfg_word(4, 1, 1));
			write_word(cnn_pool_pkg::REG_CTRL, 32'd1);
		end
		wait_done(name);
		check_value({name, " cycles"}, depth * out * out * win * win + 3, layer_cycles);
		read_word(cnn_pool_pkg::REG_CFG, q);
		check_value({name, " cfg"}, cfg_word(fm, win, depth), q);
		for (int i = 0; i < depth * out * out; i++) begin
			read_word(window_addr(i), q);
			check_value(name, {16'b0, exp_out[i[7:0]]}, q);
			fm_in[i[7:0]] = exp_out[i[7:0]]; // input of the next layer
		end
	endtask

	initial begin
		cnn_pool_pkg::wb_data_t q;
		int idx;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		rst = 1'b0;
		repeat (3) @(negedge clk);
		rst = 1'b1;

		read_word(cnn_pool_pkg::REG_STATUS, q);
		check_value("status after reset", 32'd0, q);

		// spread over the whole bank
		for (int i = 0; i < 16; i++) begin
			idx = i * 17;
			fm_in[idx[7:0]] = next_rand_fp16();
			write_word(window_addr(idx), {16'b0, fm_in[idx[7:0]]});
		end
		for (int i = 0; i < 16; i++) begin
			idx = i * 17;
			read_word(window_addr(idx), q);
			check_value("ram readback", {16'b0, fm_in[idx[7:0]]}, q);
		end

		load_map(8, 2, 2);
		run_layer("pool 8x8 w2 d2", 8, 2, 2, 1'b0);
		run_layer("chained 4x4 w2 d2", 4, 2, 2, 1'b0); // reads the swapped bank
		load_map(7, 4, 3);
		run_layer("pool 7x7 w4 d3", 7, 4, 3, 1'b0);
		load_map(8, 2, 1);
		run_layer("busy writes 8x8 w2 d1", 8, 2, 1, 1'b1);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+verif
design/cnn_pool_pkg.sv
design/fm_ram.sv
design/wb_pool_regs.sv
design/pool_addr_gen.sv
design/max_pool_unit.sv
design/pool_layer_ctrl.sv
design/cnn_pool_top.sv
verif/tb_cnn_pool.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cnn_pool
FILELIST = all.f
OBJDIR   = obj_dir
PASS_MSG = RESULT: PASS

.PHONY: compile run clean

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
